// File: hdl/ooo_pkg.sv
package ooo_pkg;

	localparam int DATA_WIDTH     = 32;
	localparam int TAG_WIDTH      = 3;
	localparam int N_TAG          = 2**TAG_WIDTH;
	localparam int N_REG          = 8;
	localparam int REG_ADDR_WIDTH = 3;
	localparam int OP_WIDTH       = 3;
	localparam int IMM_WIDTH      = 16;
	localparam int RS_DEPTH       = 2;

	typedef logic [DATA_WIDTH-1:0]     data_t;
	typedef logic [TAG_WIDTH-1:0]      rob_tag_t;
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [OP_WIDTH-1:0]       add_sub_op_t;  // [0] imm, [1] sub, [2] B << 2

	//////////////////////////////
	// Instruction word views

	typedef struct packed {
		add_sub_op_t op;
		reg_addr_t   rd;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [DATA_WIDTH-OP_WIDTH-3*REG_ADDR_WIDTH-1:0] unused;
	} inst_reg_t;

	typedef struct packed {
		add_sub_op_t op;
		reg_addr_t   rd;
		reg_addr_t   rs;
		logic [DATA_WIDTH-OP_WIDTH-2*REG_ADDR_WIDTH-IMM_WIDTH-1:0] unused;
		logic signed [IMM_WIDTH-1:0] imm;
	} inst_imm_t;

	// op[0] picks the view
	typedef union packed {
		inst_reg_t r;
		inst_imm_t i;
	} inst_word_u;

endpackage

// File: hdl/tag_alloc.sv
`timescale 1ns/1ps

module tag_alloc (
	input  logic              clk,
	input  logic              reset,
	input  logic              issue_fire,
	input  logic              cdb_valid,
	input  ooo_pkg::rob_tag_t cdb_tag,
	output ooo_pkg::rob_tag_t alloc_tag,
	output logic              tag_free_any
);
	import ooo_pkg::*;

	logic [N_TAG-1:0] busy;  // One bit per tag in flight

	// Lowest free tag wins
	always_comb begin
		alloc_tag    = '0;
		tag_free_any = 1'b0;
		for (int i = N_TAG-1; i >= 0; i--) begin
			if (!busy[i]) begin
				alloc_tag    = rob_tag_t'(i);
				tag_free_any = 1'b1;
			end
		end
	end

	// A broadcast tag is still busy here, so it never equals alloc_tag
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (cdb_valid) begin
				busy[cdb_tag] <= 1'b0;
			end
			if (issue_fire) begin
				busy[alloc_tag] <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/reg_status.sv
`timescale 1ns/1ps

module reg_status (
	input  logic                clk,
	input  logic                reset,
	input  ooo_pkg::inst_word_u inst,
	input  logic                issue_fire,
	input  ooo_pkg::rob_tag_t   alloc_tag,
	input  logic                cdb_valid,
	input  ooo_pkg::rob_tag_t   cdb_tag,
	input  ooo_pkg::data_t      cdb_data,
	input  logic                reg_wr_en,
	input  ooo_pkg::reg_addr_t  reg_wr_addr,
	input  ooo_pkg::data_t      reg_wr_data,
	output logic                src_valid [1:0],
	output ooo_pkg::rob_tag_t   src_tag [1:0],
	output ooo_pkg::data_t      src_data [1:0]
);
	import ooo_pkg::*;

	data_t            value [N_REG];
	rob_tag_t         tag [N_REG];  // Producer of the pending value
	logic [N_REG-1:0] busy;

	reg_addr_t        rs;
	reg_addr_t        rt;
	reg_addr_t        rd;
	logic [N_REG-1:0] wb_hit;
	logic [N_REG-1:0] ren_hit;

	// Same positions in both views
	assign rs = inst.r.rs;
	assign rd = inst.r.rd;
	assign rt = inst.r.rt;  // Ignored downstream in immediate form

	//////////////////////////////
	// Source read

	assign src_valid[0] = !busy[rs];
	assign src_tag[0]   = tag[rs];
	assign src_data[0]  = value[rs];

	assign src_valid[1] = !busy[rt];
	assign src_tag[1]   = tag[rt];
	assign src_data[1]  = value[rt];

	//////////////////////////////
	// Rename and writeback

	always_comb begin
		for (int r = 0; r < N_REG; r++) begin
			wb_hit[r]  = cdb_valid && busy[r] && tag[r] == cdb_tag;
			ren_hit[r] = issue_fire && rd == reg_addr_t'(r);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
		end else begin
			for (int r = 0; r < N_REG; r++) begin
				if (ren_hit[r]) begin
					busy[r] <= 1'b1;  // New producer beats the old broadcast
				end else if (wb_hit[r]) begin
					busy[r] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int r = 0; r < N_REG; r++) begin
			if (wb_hit[r]) begin
				value[r] <= cdb_data;
			end
			if (ren_hit[r]) begin
				tag[r] <= alloc_tag;
			end
		end
		// Init only, target is never busy
		if (reg_wr_en) begin
			value[reg_wr_addr] <= reg_wr_data;
		end
	end

endmodule

// File: hdl/add_sub_rs.sv
`timescale 1ns/1ps

module add_sub_rs (
	input  logic                clk,
	input  logic                reset,
	input  ooo_pkg::inst_word_u inst,
	input  logic                inst_valid,  // Already qualified by the top level
	input  ooo_pkg::rob_tag_t   alloc_tag,
	input  logic                src_valid [1:0],
	input  ooo_pkg::rob_tag_t   src_tag [1:0],
	input  ooo_pkg::data_t      src_data [1:0],
	input  logic                cdb_ready,
	output logic                issue_space,
	output logic                cdb_valid,
	output ooo_pkg::rob_tag_t   cdb_tag,
	output ooo_pkg::data_t      cdb_data
);
	import ooo_pkg::*;

	// Held entries, filled from index 0; operand 0 is A, operand 1 is B
	logic     e_valid [RS_DEPTH];
	rob_tag_t e_tag [RS_DEPTH];
	logic     e_sub [RS_DEPTH];
	logic     e_sl2 [RS_DEPTH];
	logic     opd_valid [RS_DEPTH][2];
	rob_tag_t opd_tag [RS_DEPTH][2];
	data_t    opd_data [RS_DEPTH][2];

	// Next state candidates, woken entries first and the new one last
	logic     c_valid [RS_DEPTH+1];
	rob_tag_t c_tag [RS_DEPTH+1];
	logic     c_sub [RS_DEPTH+1];
	logic     c_sl2 [RS_DEPTH+1];
	logic     c_opv [RS_DEPTH+1][2];
	rob_tag_t c_opt [RS_DEPTH+1][2];
	data_t    c_opd [RS_DEPTH+1][2];

	logic [1:0]          pick [RS_DEPTH];
	logic                fill1;
	logic [RS_DEPTH-1:0] rdy;
	logic                sel;
	logic                dispatch;
	add_sub_op_t         op;
	data_t               sext_imm;

	assign op       = inst.r.op;
	assign sext_imm = data_t'($signed(inst.i.imm));

	//////////////////////////////
	// Entry build and wakeup

	always_comb begin
		c_valid[RS_DEPTH] = inst_valid;
		c_tag[RS_DEPTH]   = alloc_tag;
		c_sub[RS_DEPTH]   = op[1];
		c_sl2[RS_DEPTH]   = op[2];

		c_opt[RS_DEPTH][0] = src_tag[1];  // A from rt
		if (op[0]) begin
			c_opv[RS_DEPTH][0] = 1'b1;
			c_opd[RS_DEPTH][0] = sext_imm;
		end else if (src_valid[1]) begin
			c_opv[RS_DEPTH][0] = 1'b1;
			c_opd[RS_DEPTH][0] = src_data[1];
		end else begin
			c_opv[RS_DEPTH][0] = cdb_valid && cdb_tag == src_tag[1];  // Same cycle catch
			c_opd[RS_DEPTH][0] = cdb_data;
		end

		c_opt[RS_DEPTH][1] = src_tag[0];  // B from rs
		c_opv[RS_DEPTH][1] = src_valid[0] || (cdb_valid && cdb_tag == src_tag[0]);
		c_opd[RS_DEPTH][1] = (src_valid[0] ? src_data[0] : cdb_data) << (op[2] ? 2 : 0);

		for (int j = 0; j < RS_DEPTH; j++) begin
			c_valid[j] = e_valid[j];
			c_tag[j]   = e_tag[j];
			c_sub[j]   = e_sub[j];
			c_sl2[j]   = e_sl2[j];
			for (int k = 0; k < 2; k++) begin
				c_opv[j][k] = opd_valid[j][k] || (cdb_valid && opd_tag[j][k] == cdb_tag);
				c_opt[j][k] = opd_tag[j][k];
			end
			c_opd[j][0] = opd_valid[j][0] ? opd_data[j][0] : cdb_data;
			c_opd[j][1] = opd_valid[j][1] ? opd_data[j][1] : cdb_data << (e_sl2[j] ? 2 : 0);
		end
	end

	//////////////////////////////
	// Dispatch and compaction

	always_comb begin
		for (int j = 0; j < RS_DEPTH; j++) begin
			rdy[j] = e_valid[j] && opd_valid[j][0] && opd_valid[j][1];
		end
	end

	assign sel         = !rdy[0];  // Oldest ready first
	assign dispatch    = |rdy && cdb_ready;
	assign issue_space = dispatch || !e_valid[RS_DEPTH-1];

	always_comb begin
		if (dispatch && !sel) begin
			pick[0] = e_valid[1] ? 2'd1 : 2'd2;  // Shift entry 1 down
			pick[1] = 2'd2;
			fill1   = e_valid[1];
		end else if (dispatch) begin
			pick[0] = 2'd0;
			pick[1] = 2'd2;
			fill1   = 1'b1;
		end else begin
			pick[0] = e_valid[0] ? 2'd0 : 2'd2;
			pick[1] = e_valid[1] ? 2'd1 : 2'd2;
			fill1   = e_valid[0];  // Entry 1 only ever follows entry 0
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int j = 0; j < RS_DEPTH; j++) begin
				e_valid[j] <= 1'b0;
			end
			cdb_valid <= 1'b0;
		end else begin
			e_valid[0] <= c_valid[pick[0]];
			e_valid[1] <= fill1 && c_valid[pick[1]];
			cdb_valid  <= dispatch;
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < RS_DEPTH; j++) begin
			e_tag[j] <= c_tag[pick[j]];
			e_sub[j] <= c_sub[pick[j]];
			e_sl2[j] <= c_sl2[pick[j]];
			for (int k = 0; k < 2; k++) begin
				opd_valid[j][k] <= c_opv[pick[j]][k];
				opd_tag[j][k]   <= c_opt[pick[j]][k];
				opd_data[j][k]  <= c_opd[pick[j]][k];
			end
		end
		cdb_tag  <= e_tag[sel];
		cdb_data <= e_sub[sel] ? opd_data[sel][0] - opd_data[sel][1]
		                       : opd_data[sel][0] + opd_data[sel][1];
	end

endmodule

// File: hdl/alu_cluster_top.sv
`timescale 1ns/1ps

module alu_cluster_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                inst_valid,
	input  ooo_pkg::inst_word_u inst,
	input  logic                cdb_ready,
	input  logic                reg_wr_en,
	input  ooo_pkg::reg_addr_t  reg_wr_addr,
	input  ooo_pkg::data_t      reg_wr_data,
	output logic                inst_ready,
	output logic                cdb_valid,
	output ooo_pkg::rob_tag_t   cdb_tag,
	output ooo_pkg::data_t      cdb_data
);
	import ooo_pkg::*;

	logic     issue_space;
	logic     tag_free_any;
	logic     issue_fire;
	rob_tag_t alloc_tag;
	logic     src_valid [1:0];
	rob_tag_t src_tag [1:0];
	data_t    src_data [1:0];

	//////////////////////////////
	// Issue handshake

	assign inst_ready = issue_space && tag_free_any && !reset;
	assign issue_fire = inst_valid && inst_ready;

	tag_alloc u_tag_alloc (
		.clk          (clk),
		.reset        (reset),
		.issue_fire   (issue_fire),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.alloc_tag    (alloc_tag),
		.tag_free_any (tag_free_any)
	);

	reg_status u_reg_status (
		.clk         (clk),
		.reset       (reset),
		.inst        (inst),
		.issue_fire  (issue_fire),
		.alloc_tag   (alloc_tag),
		.cdb_valid   (cdb_valid),  // CDB loops back here
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data),
		.reg_wr_en   (reg_wr_en),
		.reg_wr_addr (reg_wr_addr),
		.reg_wr_data (reg_wr_data),
		.src_valid   (src_valid),
		.src_tag     (src_tag),
		.src_data    (src_data)
	);

	add_sub_rs u_add_sub_rs (
		.clk         (clk),
		.reset       (reset),
		.inst        (inst),
		.inst_valid  (issue_fire),
		.alloc_tag   (alloc_tag),
		.src_valid   (src_valid),
		.src_tag     (src_tag),
		.src_data    (src_data),
		.cdb_ready   (cdb_ready),
		.issue_space (issue_space),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data)
	);

endmodule

// File: verif/tb_tasks.svh
function automatic logic [31:0] next_rand();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// x is the immediate, or holds rt in its low bits
function automatic inst_word_u make_inst(input add_sub_op_t op, input reg_addr_t rd,
		input reg_addr_t rs, input logic [15:0] x);
	inst_word_u w;
	w      = '0;
	w.r.op = op;
	w.r.rd = rd;
	w.r.rs = rs;
	if (op[0]) w.i.imm = x;
	else w.r.rt = x[2:0];
	return w;
endfunction

function automatic data_t predict(input inst_word_u w);
	data_t a;
	data_t b;
	a = w.r.op[0] ? {{16{w.i.imm[15]}}, w.i.imm} : shadow[w.r.rt];
	b = w.r.op[2] ? shadow[w.r.rs] * 4 : shadow[w.r.rs];
	return w.r.op[1] ? a - b : a + b;
endfunction

task automatic report_failure(input string msg);
	$display("%s (at %0t)", msg, $time);
	err_cnt++;
endtask

task automatic check_data(input data_t got, input data_t exp, input string what);
	if (got !== exp) begin
		$display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
		err_cnt++;
	end
endtask

task automatic check_tag(input rob_tag_t got, input rob_tag_t exp, input string what);
	if (got !== exp) begin
		$display("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp);
		err_cnt++;
	end
endtask

task automatic end_test(input string name);
	if (err_cnt == test_err0) begin
		$display("%s: ok", name);
	end else begin
		$display("%s: %0d errors", name, err_cnt - test_err0);
		fail_tests++;
	end
	test_err0 = err_cnt;
endtask

//////////////////////////////
// One clock of stimulus and monitoring

task automatic cycle(input logic v, input inst_word_u w, input logic rdy);
	rob_tag_t t;
	logic     have_tag;
	@(negedge clk);
	inst_valid = v;
	inst       = w;
	cdb_ready  = rdy;
	#(CLK_PERIOD/4);  // Inputs settled and the edge still ahead
	fired    = v && inst_ready;
	have_tag = 1'b0;
	t        = '0;
	for (int i = 0; i < N_TAG && !have_tag; i++) begin
		if (!pend[i]) begin
			t        = rob_tag_t'(i);
			have_tag = 1'b1;
		end
	end
	if (cdb_valid) begin
		bcast_cnt++;
		if (!pend[cdb_tag])
			report_failure($sformatf("Result for tag %0d arrived with nothing in flight", cdb_tag));
		else check_data(cdb_data, exp_val[cdb_tag], "cdb_data");
		pend[cdb_tag] = 1'b0;  // Free from the next edge on
		if (in_order && order_q.size() != 0) check_tag(cdb_tag, order_q.pop_front(), "cdb_tag");
	end
	if (fired && !have_tag) report_failure("Issue accepted with all tags in flight");
	if (fired && have_tag) begin
		exp_val[t]     = predict(w);
		shadow[w.r.rd] = exp_val[t];
		pend[t]        = 1'b1;
		if (in_order) order_q.push_back(t);
	end
endtask

task automatic load_reg(input reg_addr_t a, input data_t d);
	@(negedge clk);
	inst_valid  = 1'b0;
	reg_wr_en   = 1'b1;
	reg_wr_addr = a;
	reg_wr_data = d;
	@(negedge clk);
	reg_wr_en = 1'b0;
	shadow[a] = d;
endtask

task automatic issue(input inst_word_u w, input logic rand_ready);
	int n;
	n = 0;
	do begin
		cycle(1'b1, w, rand_ready ? (next_rand() % 4 != 0) : 1'b1);
		n++;
	end while (!fired && n < 100);
	if (!fired) report_failure("Instruction not accepted within 100 cycles");
endtask

task automatic drain();
	int n;
	n = 0;
	while (|pend && n < 50) begin
		cycle(1'b0, '0, 1'b1);
		n++;
	end
	for (int t = 0; t < N_TAG; t++) begin
		if (pend[t]) report_failure($sformatf("No result arrived for tag %0d", t));
	end
	pend = '0;
	repeat (3) cycle(1'b0, '0, 1'b1);  // Would show a repeated broadcast
	order_q.delete();
endtask

//////////////////////////////
// Tests

task automatic test_reg_add_sub();
	in_order = 1'b1;
	issue(make_inst(3'b000, 3'd5, 3'd2, 16'd1), 1'b0);
	issue(make_inst(3'b010, 3'd6, 3'd2, 16'd1), 1'b0);
	issue(make_inst(3'b010, 3'd7, 3'd1, 16'd3), 1'b0);
	issue(make_inst(3'b000, 3'd0, 3'd4, 16'd4), 1'b0);
	drain();
	end_test("register add and subtract");
endtask

task automatic test_imm_shift();
	in_order = 1'b1;
	issue(make_inst(3'b001, 3'd1, 3'd2, 16'hfffb), 1'b0);  // -5
	issue(make_inst(3'b011, 3'd2, 3'd3, 16'h8000), 1'b0);
	issue(make_inst(3'b101, 3'd3, 3'd4, 16'h7fff), 1'b0);
	issue(make_inst(3'b111, 3'd4, 3'd5, 16'hff00), 1'b0);
	issue(make_inst(3'b100, 3'd5, 3'd6, 16'd7), 1'b0);
	issue(make_inst(3'b110, 3'd6, 3'd7, 16'd0), 1'b0);
	drain();
	end_test("immediate forms and shift");
endtask

// Varied gaps put some issues on the producer's broadcast cycle
task automatic test_dep_chain();
	in_order = 1'b1;
	for (int i = 0; i < 9; i++) begin
		issue(make_inst(add_sub_op_t'(i), 3'd1, 3'd1, 16'(i[0] ? i * 1234 - 5000 : 1)), 1'b0);
		repeat (i % 3) cycle(1'b0, '0, 1'b1);
	end
	issue(make_inst(3'b000, 3'd2, 3'd1, 16'd1), 1'b0);
	drain();
	issue(make_inst(3'b010, 3'd3, 3'd2, 16'd1), 1'b0);
	drain();
	end_test("dependency chain");
endtask

task automatic test_back_pressure();
	int acc;
	int b0;
	in_order = 1'b1;
	acc      = 0;
	b0       = bcast_cnt;
	repeat (6) begin
		cycle(1'b1, make_inst(3'b000, reg_addr_t'(acc), 3'd3, 16'd4), 1'b0);
		if (fired) acc++;
	end
	if (acc != 2) begin
		$display("ERR @%0t: %0d issues accepted with cdb_ready low, expected 2", $time, acc);
		err_cnt++;
	end
	if (inst_ready) report_failure("inst_ready stayed high with both entries full");
	if (bcast_cnt != b0) report_failure("A result was broadcast while cdb_ready was low");
	drain();
	end_test("back-pressure");
endtask

task automatic test_random_stream();
	logic [31:0] r;
	int          stalls;
	in_order = 1'b0;
	stalls   = 0;
	repeat (200) begin
		r = next_rand();
		issue(make_inst(r[2:0], r[5:3], r[8:6], r[31:16]), 1'b1);
	end
	drain();
	// Every tag must be free again
	in_order = 1'b1;
	for (int i = 0; i < 8; i++) begin
		cycle(1'b1, make_inst(3'b000, reg_addr_t'(i), 3'd7, 16'd7), 1'b1);
		if (!fired) stalls++;
	end
	if (stalls != 0) report_failure("Issue stalled after the random stream drained");
	drain();
	end_test("random stream");
endtask

// File: verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	import ooo_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int N_TESTS    = 5;

	logic       clk;
	logic       reset;
	logic       inst_valid;
	inst_word_u inst;
	logic       cdb_ready;
	logic       reg_wr_en;
	reg_addr_t  reg_wr_addr;
	data_t      reg_wr_data;
	logic       inst_ready;
	logic       cdb_valid;
	rob_tag_t   cdb_tag;
	data_t      cdb_data;

	//////////////////////////////
	// Model of the core

	data_t            shadow [N_REG];  // Register values in program order
	logic [N_TAG-1:0] pend;            // Tags in flight
	data_t            exp_val [N_TAG];
	rob_tag_t         order_q [$];
	logic             in_order;  // Results come back in issue order
	logic             fired;
	int               bcast_cnt;
	int               err_cnt;
	int               test_err0;
	int               fail_tests;
	logic [31:0]      rng_state;

	alu_cluster_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Watchdog
	initial begin
		#(N_TESTS * 400 * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	`include "tb_tasks.svh"

	initial begin
		reset       = 1'b1;
		inst_valid  = 1'b0;
		inst        = '0;
		cdb_ready   = 1'b0;
		reg_wr_en   = 1'b0;
		reg_wr_addr = '0;
		reg_wr_data = '0;
		pend        = '0;
		in_order    = 1'b0;
		fired       = 1'b0;
		bcast_cnt   = 0;
		err_cnt     = 0;
		fail_tests  = 0;
		rng_state   = 32'd97;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < N_REG; r++) begin
			load_reg(reg_addr_t'(r), data_t'(next_rand()));
		end
		test_err0 = err_cnt;
		test_reg_add_sub();
		test_imm_shift();
		test_dep_chain();
		test_back_pressure();
		test_random_stream();
		$display("%0d tests, %0d failed, %0d errors", N_TESTS, fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+verif
hdl/ooo_pkg.sv
hdl/tag_alloc.sv
hdl/reg_status.sv
hdl/add_sub_rs.sv
hdl/alu_cluster_top.sv
verif/tb_top.sv
